// File: build.f
hdl/mips_pkg.sv
hdl/mc_control.sv
hdl/pc_ir_unit.sv
hdl/reg_file.sv
hdl/alu_unit.sv
hdl/unified_mem.sv
hdl/mc_computer.sv
tests/mc_computer_sva.sv
tests/tb_mc_computer.sv

// File: hdl/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
  input  wire                   clk,
  input  wire                   clrn,
  input  wire mips_pkg::ctrl_t  i_ctrl,
  input  wire mips_pkg::instr_t i_ir,
  input  wire mips_pkg::word_t  i_pc,
  input  wire mips_pkg::word_t  i_reg_a,
  input  wire mips_pkg::word_t  i_reg_b,
  output mips_pkg::word_t       o_alu_r,
  output mips_pkg::word_t       o_alu_c,
  output logic                  o_zero
);
  import mips_pkg::*;

  logic  sign;               // extension bit
  word_t imm32;              // extended immediate
  word_t ofs32;              // word offset for branches
  word_t opa, opb;           // alu operands
  word_t d_as, d_lg, d_xl;   // grouped results
  word_t d_sh;               // shifter out

  assign sign  = i_ctrl.sext & i_ir.i.imm[imm_w-1];
  assign imm32 = {{(word_w-imm_w){sign}}, i_ir.i.imm};
  assign ofs32 = {{(word_w-imm_w-2){sign}}, i_ir.i.imm, 2'b00};

  always_comb begin
    if (i_ctrl.selpc)      opa = i_pc;
    else if (i_ctrl.shift) opa = {{(word_w-5){1'b0}}, i_ir.r.shamt};
    else                   opa = i_reg_a;
    case (i_ctrl.alusrcb)
      srcb_b:    opb = i_reg_b;
      srcb_four: opb = 32'd4;
      srcb_imm:  opb = imm32;
      srcb_ofs:  opb = ofs32;
      default:   opb = i_reg_b;
    endcase
  end

  assign d_as = i_ctrl.aluc.alt ? (opa - opb) : (opa + opb);
  assign d_lg = i_ctrl.aluc.alt ? (opa | opb) : (opa & opb);
  assign d_xl = i_ctrl.aluc.alt ? {opb[15:0], 16'h0} : (opa ^ opb); // lui or xor

  always_comb begin          // barrel shift of b by a[4:0]
    if (!i_ctrl.aluc.alt) begin
      d_sh = opb << opa[4:0];
    end else if (!i_ctrl.aluc.arith) begin
      d_sh = opb >> opa[4:0];
    end else begin
      d_sh = $signed(opb) >>> opa[4:0];
    end
  end

  always_comb begin
    case (i_ctrl.aluc.sel)
      2'd0:    o_alu_r = d_as;
      2'd1:    o_alu_r = d_lg;
      2'd2:    o_alu_r = d_xl;
      default: o_alu_r = d_sh;
    endcase
  end

  assign o_zero = ~|o_alu_r; // beq/bne compare

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_alu_c <= '0;
    end else begin
      o_alu_c <= o_alu_r;    // C every cycle
    end
  end

endmodule

`default_nettype wire

// File: hdl/mc_computer.sv
`timescale 1ns/100ps
`default_nettype none

module mc_computer (
  input  wire                clk,
  input  wire                clrn,
  output mips_pkg::state_t   o_state,
  output mips_pkg::word_t    o_pc,
  output mips_pkg::instr_t   o_ir,
  output mips_pkg::word_t    o_mem_addr,
  output mips_pkg::word_t    o_mem_wdata,
  output logic               o_mem_we,
  output mips_pkg::word_t    o_alu_r
);
  import mips_pkg::*;

  ctrl_t  ctrl;              // control bus
  instr_t ir;
  word_t  pc, mdr, mem_addr, mem_rdata;
  word_t  alu_r, alu_c;      // alu out, register C
  word_t  rs_val, reg_a, reg_b;
  logic   zero;

  mc_control u_control (
    .clk, .clrn,
    .i_ir(ir), .i_zero(zero),
    .o_ctrl(ctrl), .o_state(o_state)
  );

  pc_ir_unit u_pc_ir (
    .clk, .clrn,
    .i_ctrl(ctrl), .i_mem_rdata(mem_rdata),
    .i_alu_r(alu_r), .i_alu_c(alu_c), .i_rs_val(rs_val),
    .o_pc(pc), .o_ir(ir), .o_mdr(mdr), .o_mem_addr(mem_addr)
  );

  reg_file u_reg_file (
    .clk, .clrn,
    .i_ctrl(ctrl), .i_ir(ir),
    .i_alu_c(alu_c), .i_mdr(mdr), .i_pc(pc),
    .o_rs_val(rs_val), .o_reg_a(reg_a), .o_reg_b(reg_b)
  );

  alu_unit u_alu (
    .clk, .clrn,
    .i_ctrl(ctrl), .i_ir(ir), .i_pc(pc),
    .i_reg_a(reg_a), .i_reg_b(reg_b),
    .o_alu_r(alu_r), .o_alu_c(alu_c), .o_zero(zero)
  );

  unified_mem u_mem (
    .clk,
    .i_we(ctrl.wmem), .i_addr(mem_addr), .i_wdata(reg_b), // store data is B
    .o_rdata(mem_rdata)
  );

  assign o_pc        = pc;
  assign o_ir        = ir;
  assign o_mem_addr  = mem_addr;
  assign o_mem_wdata = reg_b;
  assign o_mem_we    = ctrl.wmem;
  assign o_alu_r     = alu_r;

endmodule

`default_nettype wire

// File: hdl/mc_control.sv
`timescale 1ns/100ps
`default_nettype none

module mc_control (
  input  wire                 clk,
  input  wire                 clrn,
  input  wire mips_pkg::instr_t i_ir,
  input  wire                 i_zero,
  output mips_pkg::ctrl_t     o_ctrl,
  output mips_pkg::state_t    o_state
);
  import mips_pkg::*;

  state_t state, next_state;
  logic rtype, i_sub, i_and, i_or, i_xor, i_sll, i_srl, i_sra, i_jr;
  logic i_addi, i_andi, i_ori, i_xori, i_lui, i_lw, i_sw, i_beq, i_bne;
  logic i_j, i_jal, i_shift, i_imm_alu;

  assign rtype  = (i_ir.r.op == op_rtype);             // r format
  assign i_sub  = rtype & (i_ir.r.funct == fn_sub);
  assign i_and  = rtype & (i_ir.r.funct == fn_and);
  assign i_or   = rtype & (i_ir.r.funct == fn_or);
  assign i_xor  = rtype & (i_ir.r.funct == fn_xor);
  assign i_sll  = rtype & (i_ir.r.funct == fn_sll);
  assign i_srl  = rtype & (i_ir.r.funct == fn_srl);
  assign i_sra  = rtype & (i_ir.r.funct == fn_sra);
  assign i_jr   = rtype & (i_ir.r.funct == fn_jr);
  assign i_addi = (i_ir.i.op == op_addi);              // i format
  assign i_andi = (i_ir.i.op == op_andi);
  assign i_ori  = (i_ir.i.op == op_ori);
  assign i_xori = (i_ir.i.op == op_xori);
  assign i_lui  = (i_ir.i.op == op_lui);
  assign i_lw   = (i_ir.i.op == op_lw);
  assign i_sw   = (i_ir.i.op == op_sw);
  assign i_beq  = (i_ir.i.op == op_beq);
  assign i_bne  = (i_ir.i.op == op_bne);
  assign i_j    = (i_ir.j.op == op_j);                 // j format
  assign i_jal  = (i_ir.j.op == op_jal);

  assign i_shift   = i_sll | i_srl | i_sra;
  assign i_imm_alu = i_addi | i_andi | i_ori | i_xori | i_lui; // takes immediate

  always_comb begin
    o_ctrl         = '0;         // all strobes low
    o_ctrl.sext    = 1'b1;       // sign extend by default
    o_ctrl.aluc    = aluc_add;
    o_ctrl.alusrcb = srcb_b;
    o_ctrl.pcsrc   = pc_alu;
    next_state     = st_if;
    case (state)
      st_if: begin
        o_ctrl.wpc     = 1'b1;     // pc <= pc + 4
        o_ctrl.wir     = 1'b1;     // ir <= mem[pc]
        o_ctrl.selpc   = 1'b1;
        o_ctrl.alusrcb = srcb_four;
        next_state     = st_id;
      end
      st_id: begin
        if (i_j || i_jal) begin
          o_ctrl.pcsrc = pc_jmp;   // jump target
          o_ctrl.wpc   = 1'b1;
          o_ctrl.jal   = i_jal;    // link into r31
          o_ctrl.wreg  = i_jal;
        end else if (i_jr) begin
          o_ctrl.pcsrc = pc_rs;    // jump register
          o_ctrl.wpc   = 1'b1;
        end else begin
          o_ctrl.selpc   = 1'b1;   // C <= pc + offset as branch target
          o_ctrl.alusrcb = srcb_ofs;
          next_state     = st_exe;
        end
      end
      st_exe: begin
        if (i_sub)                  o_ctrl.aluc = aluc_sub;
        else if (i_and || i_andi)   o_ctrl.aluc = aluc_and;
        else if (i_or || i_ori)     o_ctrl.aluc = aluc_or;
        else if (i_xor || i_xori)   o_ctrl.aluc = aluc_xor;
        else if (i_beq || i_bne)    o_ctrl.aluc = aluc_xor; // compare via xor
        else if (i_lui)             o_ctrl.aluc = aluc_lui;
        else if (i_sll)             o_ctrl.aluc = aluc_sll;
        else if (i_srl)             o_ctrl.aluc = aluc_srl;
        else if (i_sra)             o_ctrl.aluc = aluc_sra;
        else                        o_ctrl.aluc = aluc_add; // add, addi, lw, sw
        if (i_beq || i_bne) begin
          o_ctrl.pcsrc = pc_c;     // target computed in ID
          o_ctrl.wpc   = (i_beq & i_zero) | (i_bne & ~i_zero);
        end else if (i_lw || i_sw) begin
          o_ctrl.alusrcb = srcb_imm; // base + offset
          next_state     = st_mem;
        end else begin
          o_ctrl.shift = i_shift;  // a = shamt
          if (i_imm_alu) o_ctrl.alusrcb = srcb_imm;
          o_ctrl.sext  = ~(i_andi | i_ori | i_xori); // logic imm zero extended
          next_state   = st_wb;
        end
      end
      st_mem: begin
        o_ctrl.iord = 1'b1;        // address from C
        if (i_lw) begin
          next_state = st_wb;      // data register catches word
        end else begin
          o_ctrl.wmem = 1'b1;      // store B
        end
      end
      st_wb: begin
        o_ctrl.m2reg = i_lw;
        o_ctrl.regrt = i_lw | i_imm_alu;
        o_ctrl.wreg  = 1'b1;
      end
      default: next_state = st_if;
    endcase
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      state <= st_if;
    end else begin
      state <= next_state;
    end
  end

  assign o_state = state;

endmodule

`default_nettype wire

// File: hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

  localparam int word_w     = 32; // datapath width
  localparam int reg_addr_w = 5;  // register number
  localparam int imm_w      = 16; // immediate field
  localparam int mem_words  = 64; // memory depth
  localparam int mem_addr_w = 6;  // memory word index

  typedef logic [word_w-1:0]     word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  localparam logic [5:0] op_rtype = 6'h00; // major opcodes
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jal   = 6'h03;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_xori  = 6'h0e;
  localparam logic [5:0] op_lui   = 6'h0f;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  localparam logic [5:0] fn_sll = 6'h00; // r-format funct field
  localparam logic [5:0] fn_srl = 6'h02;
  localparam logic [5:0] fn_sra = 6'h03;
  localparam logic [5:0] fn_jr  = 6'h08;
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_xor = 6'h26;

  localparam reg_addr_t reg_link = 5'd31; // jal return address

  localparam logic [1:0] srcb_b    = 2'd0; // alu b from register B
  localparam logic [1:0] srcb_four = 2'd1; // alu b is constant 4
  localparam logic [1:0] srcb_imm  = 2'd2; // alu b from immediate
  localparam logic [1:0] srcb_ofs  = 2'd3; // alu b from branch offset

  localparam logic [1:0] pc_alu = 2'd0; // next pc from alu result
  localparam logic [1:0] pc_c   = 2'd1; // next pc from register C
  localparam logic [1:0] pc_rs  = 2'd2; // next pc from rs value
  localparam logic [1:0] pc_jmp = 2'd3; // next pc from jump target

  typedef enum logic [2:0] {
    st_if  = 3'd0,
    st_id  = 3'd1,
    st_exe = 3'd2,
    st_mem = 3'd3,
    st_wb  = 3'd4
  } state_t;

  typedef struct packed {
    logic       arith; // arithmetic right shift
    logic       alt;   // sub / or / lui / shift right
    logic [1:0] sel;   // result group
  } aluc_t;

  localparam aluc_t aluc_add = 4'b0000;
  localparam aluc_t aluc_and = 4'b0001;
  localparam aluc_t aluc_xor = 4'b0010;
  localparam aluc_t aluc_sll = 4'b0011;
  localparam aluc_t aluc_sub = 4'b0100;
  localparam aluc_t aluc_or  = 4'b0101;
  localparam aluc_t aluc_lui = 4'b0110;
  localparam aluc_t aluc_srl = 4'b0111;
  localparam aluc_t aluc_sra = 4'b1111;

  typedef struct packed {
    logic [5:0] op;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } instr_r_t;

  typedef struct packed {
    logic [5:0]       op;
    reg_addr_t        rs;
    reg_addr_t        rt;
    logic [imm_w-1:0] imm;
  } instr_i_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } instr_j_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_j_t j;
  } instr_t;

  typedef struct packed {
    logic       wpc;     // write pc
    logic       wir;     // write ir
    logic       wmem;    // write memory
    logic       wreg;    // write register file
    logic       iord;    // memory address is C
    logic       regrt;   // destination is rt
    logic       m2reg;   // write back data register
    logic       shift;   // alu a is shamt
    logic       selpc;   // alu a is pc
    logic [1:0] alusrcb; // alu b select
    logic [1:0] pcsrc;   // next pc select
    logic       jal;     // dest 31 and data pc
    logic       sext;    // sign extend immediate
    aluc_t      aluc;
  } ctrl_t;

endpackage

`default_nettype wire

// File: hdl/pc_ir_unit.sv
`timescale 1ns/100ps
`default_nettype none

module pc_ir_unit (
  input  wire                   clk,
  input  wire                   clrn,
  input  wire mips_pkg::ctrl_t  i_ctrl,
  input  wire mips_pkg::word_t  i_mem_rdata,
  input  wire mips_pkg::word_t  i_alu_r,
  input  wire mips_pkg::word_t  i_alu_c,
  input  wire mips_pkg::word_t  i_rs_val,
  output mips_pkg::word_t       o_pc,
  output mips_pkg::instr_t      o_ir,
  output mips_pkg::word_t       o_mdr,
  output mips_pkg::word_t       o_mem_addr
);
  import mips_pkg::*;

  word_t jpc;  // jump target
  word_t npc;  // next pc

  assign jpc = {o_pc[31:28], o_ir.j.target, 2'b00}; // upper pc bits kept

  always_comb begin
    case (i_ctrl.pcsrc)
      pc_alu:  npc = i_alu_r;  // pc + 4
      pc_c:    npc = i_alu_c;  // branch target
      pc_rs:   npc = i_rs_val; // jr
      pc_jmp:  npc = jpc;      // j / jal
      default: npc = i_alu_r;
    endcase
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_pc  <= '0;
      o_ir  <= '0;
      o_mdr <= '0;
    end else begin
      if (i_ctrl.wpc) o_pc <= npc;
      if (i_ctrl.wir) o_ir <= i_mem_rdata;
      o_mdr <= i_mem_rdata;    // free running for lw
    end
  end

  assign o_mem_addr = i_ctrl.iord ? i_alu_c : o_pc; // data or fetch

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire                   clk,
  input  wire                   clrn,
  input  wire mips_pkg::ctrl_t  i_ctrl,
  input  wire mips_pkg::instr_t i_ir,
  input  wire mips_pkg::word_t  i_alu_c,
  input  wire mips_pkg::word_t  i_mdr,
  input  wire mips_pkg::word_t  i_pc,
  output mips_pkg::word_t       o_rs_val,
  output mips_pkg::word_t       o_reg_a,
  output mips_pkg::word_t       o_reg_b
);
  import mips_pkg::*;

  word_t     regs [1:31]; // r0 not stored
  word_t     qb;          // rt read port
  word_t     wd;          // write data
  reg_addr_t wn;          // write register

  assign o_rs_val = (i_ir.r.rs == '0) ? '0 : regs[i_ir.r.rs];
  assign qb       = (i_ir.r.rt == '0) ? '0 : regs[i_ir.r.rt];

  assign wn = i_ctrl.jal   ? reg_link :
              i_ctrl.regrt ? i_ir.r.rt : i_ir.r.rd;
  assign wd = i_ctrl.jal   ? i_pc :           // pc already + 4
              i_ctrl.m2reg ? i_mdr : i_alu_c;

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (i_ctrl.wreg && (wn != '0)) begin
      regs[wn] <= wd;          // writes to r0 dropped
    end
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_reg_a <= '0;
      o_reg_b <= '0;
    end else begin
      o_reg_a <= o_rs_val;     // A every cycle
      o_reg_b <= qb;           // B every cycle
    end
  end

endmodule

`default_nettype wire

// File: hdl/unified_mem.sv
`timescale 1ns/100ps
`default_nettype none

module unified_mem (
  input  wire                  clk,
  input  wire                  i_we,
  input  wire mips_pkg::word_t i_addr,
  input  wire mips_pkg::word_t i_wdata,
  output mips_pkg::word_t      o_rdata
);
  import mips_pkg::*;

  word_t                 ram [0:mem_words-1];
  logic [mem_addr_w-1:0] idx; // word index

  initial begin
    $readmemh("prog.mem", ram); // program and data image
  end

  assign idx     = i_addr[mem_addr_w+1:2];
  assign o_rdata = ram[idx];    // async read

  always_ff @(posedge clk) begin
    if (i_we) ram[idx] <= i_wdata;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mc_computer -Mdir obj_dir -f build.f

# memory image is loaded by its bare name, so run next to it
(cd tests && ../obj_dir/Vtb_mc_computer) > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi

// File: tests/mc_computer_sva.sv
`timescale 1ns/100ps
`default_nettype none

module mc_computer_sva (
  input  wire                   clk,
  input  wire                   clrn,
  input  wire mips_pkg::state_t i_state,
  input  wire mips_pkg::word_t  i_pc,
  input  wire mips_pkg::instr_t i_ir,
  input  wire mips_pkg::word_t  i_mem_rdata,
  input  wire                   i_mem_we
);
  import mips_pkg::*;

  int unsigned fail_count = 0; // failed assertion count
  int unsigned cnt;            // cycles since last IF

  function automatic int unsigned latency_of(instr_t ir);
    case (ir.i.op)
      op_rtype:        return (ir.r.funct == fn_jr) ? 2 : 4;
      op_j, op_jal:    return 2;
      op_beq, op_bne:  return 3;
      op_lw:           return 5;
      default:         return 4; // alu immediates and sw
    endcase
  endfunction

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      cnt <= 0;
    end else if (i_state == st_if) begin
      cnt <= 1;
    end else begin
      cnt <= cnt + 1;
    end
  end

  a_if_next: assert property (@(posedge clk) disable iff (!clrn)
    i_state == st_if |=> i_state == st_id)
    else begin
      fail_count = fail_count + 1;
      $error("IF not followed by ID");
    end

  a_id_next: assert property (@(posedge clk) disable iff (!clrn)
    i_state == st_id |=> i_state inside {st_if, st_exe})
    else begin
      fail_count = fail_count + 1;
      $error("illegal state after ID");
    end

  a_exe_next: assert property (@(posedge clk) disable iff (!clrn)
    i_state == st_exe |=> i_state inside {st_if, st_mem, st_wb})
    else begin
      fail_count = fail_count + 1;
      $error("illegal state after EXE");
    end

  a_mem_next: assert property (@(posedge clk) disable iff (!clrn)
    i_state == st_mem |=> i_state inside {st_if, st_wb})
    else begin
      fail_count = fail_count + 1;
      $error("illegal state after MEM");
    end

  a_wb_next: assert property (@(posedge clk) disable iff (!clrn)
    i_state == st_wb |=> i_state == st_if)
    else begin
      fail_count = fail_count + 1;
      $error("WB not followed by IF");
    end

  // pc advances by one word and ir takes the word at the old pc
  a_fetch: assert property (@(posedge clk) disable iff (!clrn)
    i_state == st_if |=> (i_pc == $past(i_pc) + 32'd4) && (i_ir == $past(i_mem_rdata)))
    else begin
      fail_count = fail_count + 1;
      $error("fetch did not update pc or ir");
    end

  a_latency: assert property (@(posedge clk) disable iff (!clrn)
    (i_state == st_if && cnt != 0) |-> cnt == latency_of(i_ir))
    else begin
      fail_count = fail_count + 1;
      $error("wrong instruction latency");
    end

  a_mem_we: assert property (@(posedge clk) disable iff (!clrn)
    i_mem_we |-> (i_state == st_mem) && (i_ir.i.op == op_sw))
    else begin
      fail_count = fail_count + 1;
      $error("memory write outside sw MEM");
    end

endmodule

`default_nettype wire

// File: tests/prog.mem
// one 32-bit word per line in hex, starting at byte address 0
// the text after each word gives its address and assembly
20010123 // 00 addi r1, r0, 0x0123
3402F0F0 // 04 ori  r2, r0, 0xf0f0
3C038000 // 08 lui  r3, 0x8000
2004FFF8 // 0c addi r4, r0, -8
00222820 // 10 add  r5, r1, r2
AC0500C0 // 14 sw   r5, 0xc0(r0)
00223022 // 18 sub  r6, r1, r2
AC0600C4 // 1c sw   r6, 0xc4(r0)
00223824 // 20 and  r7, r1, r2
AC0700C8 // 24 sw   r7, 0xc8(r0)
00224025 // 28 or   r8, r1, r2
AC0800CC // 2c sw   r8, 0xcc(r0)
00224826 // 30 xor  r9, r1, r2
AC0900D0 // 34 sw   r9, 0xd0(r0)
00015100 // 38 sll  r10, r1, 4
AC0A00D4 // 3c sw   r10, 0xd4(r0)
00035902 // 40 srl  r11, r3, 4
AC0B00D8 // 44 sw   r11, 0xd8(r0)
00036103 // 48 sra  r12, r3, 4
AC0C00DC // 4c sw   r12, 0xdc(r0)
308DFF0F // 50 andi r13, r4, 0xff0f
AC0D00E0 // 54 sw   r13, 0xe0(r0)
388E8000 // 58 xori r14, r4, 0x8000
AC0E00E4 // 5c sw   r14, 0xe4(r0)
10220001 // 60 beq  r1, r2, +1   not taken
14220001 // 64 bne  r1, r2, +1   taken
AC0000C0 // 68 sw   r0, 0xc0(r0) skipped
0800001D // 6c j    0x74
AC0000C4 // 70 sw   r0, 0xc4(r0) skipped
0C000022 // 74 jal  0x88
AC1F00E8 // 78 sw   r31, 0xe8(r0)
8C1000C0 // 7c lw   r16, 0xc0(r0)
AC1000EC // 80 sw   r16, 0xec(r0)
08000021 // 84 j    0x84         self jump
03E00008 // 88 jr   r31

// File: tests/tb_mc_computer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mc_computer;
  import mips_pkg::*;

  localparam int n_stores       = 12;
  localparam int timeout_cycles = 2000;

  typedef struct packed {
    word_t addr; // store address
    word_t data; // store data
  } store_t;

  logic   clk;
  logic   clrn;
  state_t state;
  word_t  pc;
  instr_t ir;
  word_t  mem_addr, mem_wdata, alu_r;
  logic   mem_we;
  store_t exp_store [n_stores];  // expected stores in program order
  int     store_idx;
  int     cycles;
  word_t  prev_fetch;
  logic   have_prev;

  mc_computer i_dut (
    .clk, .clrn,
    .o_state(state), .o_pc(pc), .o_ir(ir),
    .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata), .o_mem_we(mem_we),
    .o_alu_r(alu_r)
  );

  bind mc_computer mc_computer_sva u_sva (
    .clk(clk), .clrn(clrn),
    .i_state(o_state), .i_pc(o_pc), .i_ir(o_ir),
    .i_mem_rdata(mem_rdata), .i_mem_we(o_mem_we)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;           // 8 ns period

  task automatic fail_and_stop();
    $display("Verification failed");
    $fatal(1);
  endtask

  // hand-worked results of the program stores
  task automatic load_store_table();
    exp_store[0]  = '{addr: 32'hc0, data: 32'h0000f213}; // add
    exp_store[1]  = '{addr: 32'hc4, data: 32'hffff1033}; // sub
    exp_store[2]  = '{addr: 32'hc8, data: 32'h00000020}; // and
    exp_store[3]  = '{addr: 32'hcc, data: 32'h0000f1f3}; // or
    exp_store[4]  = '{addr: 32'hd0, data: 32'h0000f1d3}; // xor
    exp_store[5]  = '{addr: 32'hd4, data: 32'h00001230}; // sll
    exp_store[6]  = '{addr: 32'hd8, data: 32'h08000000}; // srl
    exp_store[7]  = '{addr: 32'hdc, data: 32'hf8000000}; // sra
    exp_store[8]  = '{addr: 32'he0, data: 32'h0000ff08}; // andi zero ext
    exp_store[9]  = '{addr: 32'he4, data: 32'hffff7ff8}; // xori zero ext
    exp_store[10] = '{addr: 32'he8, data: 32'h00000078}; // jal link
    exp_store[11] = '{addr: 32'hec, data: 32'h0000f213}; // lw round trip
  endtask

  // next fetch address known from the program layout
  function automatic word_t expected_fetch(word_t prev);
    case (prev)
      32'h64:  return 32'h6c;     // bne taken
      32'h6c:  return 32'h74;     // j
      32'h74:  return 32'h88;     // jal
      32'h84:  return 32'h84;     // self jump
      32'h88:  return 32'h78;     // jr back to link
      default: return prev + 32'd4; // incl. beq not taken
    endcase
  endfunction

  always @(negedge clk) begin
    if (clrn) begin
      if (i_dut.u_sva.fail_count != 0) begin
        $display("a bound assertion failed before %0t", $time);
        fail_and_stop();
      end
      if (state == st_if) begin
        if (have_prev) begin
          assert (pc == expected_fetch(prev_fetch)) else begin
            $display("CHECK FAILED @%0t: fetch after %h at %h, expected %h",
                     $time, prev_fetch, pc, expected_fetch(prev_fetch));
            fail_and_stop();
          end
        end
        assert (alu_r == pc + 32'd4) else begin  // alu forms the next pc in fetch
          $display("CHECK FAILED @%0t: alu gave %h in fetch at %h, expected %h",
                   $time, alu_r, pc, pc + 32'd4);
          fail_and_stop();
        end
        prev_fetch = pc;
        have_prev  = 1'b1;
      end
      if (mem_we) begin
        if (store_idx >= n_stores) begin
          $display("unexpected extra store to address %h", mem_addr);
          fail_and_stop();
        end
        assert ({mem_addr, mem_wdata} == exp_store[store_idx]) else begin
          $display("CHECK FAILED @%0t: store %0d got %h <= %h, expected %h <= %h",
                   $time, store_idx, mem_addr, mem_wdata,
                   exp_store[store_idx].addr, exp_store[store_idx].data);
          fail_and_stop();
        end
        store_idx = store_idx + 1;
      end
    end
  end

  initial begin
    clrn      = 1'b0;
    store_idx = 0;
    have_prev = 1'b0;
    load_store_table();
    repeat (16) @(posedge clk);
    clrn <= 1'b1;
    @(negedge clk);
    assert (state == st_if && pc == '0) else begin
      $display("CHECK FAILED @%0t: after reset state %0d pc %h", $time, state, pc);
      fail_and_stop();
    end
    cycles = 0;
    while (store_idx < n_stores && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    if (store_idx < n_stores) begin
      $display("timeout: only %0d of %0d stores seen", store_idx, n_stores);
      fail_and_stop();
    end
    repeat (40) @(posedge clk);   // self jump, no further store
    if (i_dut.u_sva.fail_count != 0) begin
      $display("a bound assertion failed %0d times", i_dut.u_sva.fail_count);
      fail_and_stop();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
